//--- logic/mem_pkg.sv
/*
  client port types shared by the bridge and the testbench
  addresses are byte addresses, data is always carried as a 32-bit word
  a read kind is only complete together with its sign flag
*/
package mem_pkg;

  // read size, sign carried separately in mem_req_t
  typedef enum logic [1:0] {
    rd_none,
    rd_byte,
    rd_half,
    rd_word
  } read_kind_e;

  typedef enum logic [1:0] {
    wr_none,
    wr_byte,
    wr_half,
    wr_word
  } write_kind_e;

  // client request, held by the client until data_out_ready
  typedef struct packed {
    logic        enable;
    read_kind_e  read_kind;
    logic        read_signed;
    write_kind_e write_kind;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        data_out_ready;
    logic        busy;
  } mem_rsp_t;

  // byte-enabled word write toward the RAM
  typedef struct packed {
    logic [3:0]  be;
    logic [31:0] data;
  } ram_wr_t;

endpackage

//--- logic/io_pkg.sv
/*
  I/O map at the top of the address space and UART frame states
  only exact word addresses decode, no mirrors
*/
package io_pkg;

  // leds in the low nibble, 0 is on
  localparam logic [31:0] addr_led      = 32'hffff_fffc;
  localparam logic [31:0] addr_uart_out = 32'hffff_fff8;
  localparam logic [31:0] addr_uart_in  = 32'hffff_fff4;

  // uart registers read this when idle or empty
  localparam logic [31:0] io_idle = 32'hffff_ffff;

  typedef enum logic [1:0] {
    uart_idle,
    uart_start,
    uart_data,
    uart_stop
  } uart_state_e;

endpackage

//--- logic/lane_align.sv
/*
  lane steering between client accesses and the 32-bit RAM word
  misaligned half or word accesses give no enables and read zero
  purely combinational, the decode is done by the caller
*/
module lane_align (
  input  mem_pkg::mem_req_t req,
  input  logic [31:0]       ram_rd,
  output mem_pkg::ram_wr_t  wr,
  output logic [31:0]       rd_ext
);

  logic [1:0]  lane;
  logic [31:0] rd_shift;

  assign lane     = req.addr[1:0];
  // addressed byte or half word moved down to bit 0
  assign rd_shift = ram_rd >> {lane, 3'b000};

  // ------------------------------------------------------------
  // write lanes
  // ------------------------------------------------------------
  always_comb begin
    wr.be   = 4'b0000;
    wr.data = 32'h0;
    case (req.write_kind)
      mem_pkg::wr_byte: begin
        wr.be   = 4'b0001 << lane;
        wr.data = {24'h0, req.wdata[7:0]} << {lane, 3'b000};
      end
      mem_pkg::wr_half: begin
        // odd byte address is misaligned
        if (!lane[0]) begin
          wr.be   = lane[1] ? 4'b1100 : 4'b0011;
          wr.data = {16'h0, req.wdata[15:0]} << {lane, 3'b000};
        end
      end
      mem_pkg::wr_word: begin
        if (lane == 2'b00) begin
          wr.be   = 4'b1111;
          wr.data = req.wdata;
        end
      end
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // read extraction
  // ------------------------------------------------------------
  always_comb begin
    rd_ext = 32'h0;
    case (req.read_kind)
      mem_pkg::rd_byte: begin
        rd_ext = {{24{req.read_signed & rd_shift[7]}}, rd_shift[7:0]};
      end
      mem_pkg::rd_half: begin
        if (!lane[0]) begin
          rd_ext = {{16{req.read_signed & rd_shift[15]}}, rd_shift[15:0]};
        end
      end
      mem_pkg::rd_word: begin
        if (lane == 2'b00) begin
          rd_ext = ram_rd;
        end
      end
      default: ;
    endcase
  end

endmodule

//--- logic/word_ram.sv
/*
  on-chip word RAM, one port, byte write enables
  read data is registered every cycle, so it lags the address by one
  a write and read of the same word in one cycle returns the old word
  contents are undefined after power up
*/
module word_ram #(
  parameter int ram_address_bits = 8
) (
  input  logic                        clk,
  input  logic [ram_address_bits-1:0] addr,
  input  logic [3:0]                  we,
  input  logic [31:0]                 wdata,
  output logic [31:0]                 rdata
);

  logic [31:0] mem [2**ram_address_bits];

  always_ff @(posedge clk) begin
    // each lane written on its own enable
    for (int i = 0; i < 4; i++) begin
      if (we[i]) begin
        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
    rdata <= mem[addr];
  end

endmodule

//--- logic/uart_tx.sv
/*
  8N1 transmitter, LSB first, clocks_per_bit cycles per bit
  go/busy four-phase handshake, busy follows go at once
  data must be stable in the cycle go rises
*/
module uart_tx #(
  parameter int clocks_per_bit = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,
  input  logic       go,
  output logic       busy,
  output logic       tx
);

  localparam int cnt_w = clocks_per_bit > 1 ? $clog2(clocks_per_bit) : 1;

  io_pkg::uart_state_e state;
  logic [cnt_w-1:0]    cnt;
  logic [2:0]          idx;
  logic [7:0]          shift;
  // frame sent, waiting for go to fall
  logic                done;
  logic                bit_end;

  assign bit_end = cnt == cnt_w'(clocks_per_bit - 1);
  assign busy    = go && !done;

  // line level straight from the state
  always_comb begin
    case (state)
      io_pkg::uart_start: tx = 1'b0;
      io_pkg::uart_data:  tx = shift[0];
      default:            tx = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= io_pkg::uart_idle;
      cnt   <= '0;
      idx   <= '0;
      done  <= 1'b0;
    end else begin
      cnt <= (state == io_pkg::uart_idle || bit_end) ? '0 : cnt + 1'b1;
      if (!go) begin
        done <= 1'b0;
      end
      case (state)
        io_pkg::uart_idle: begin
          if (go && !done) begin
            state <= io_pkg::uart_start;
          end
        end
        io_pkg::uart_start: begin
          if (bit_end) begin
            state <= io_pkg::uart_data;
            idx   <= '0;
          end
        end
        io_pkg::uart_data: begin
          if (bit_end) begin
            idx <= idx + 1'b1;
            if (idx == 3'd7) begin
              state <= io_pkg::uart_stop;
            end
          end
        end
        io_pkg::uart_stop: begin
          if (bit_end) begin
            state <= io_pkg::uart_idle;
            done  <= 1'b1;
          end
        end
        default: state <= io_pkg::uart_idle;
      endcase
    end
  end

  // shift register, payload only
  always_ff @(posedge clk) begin
    if (state == io_pkg::uart_idle) begin
      shift <= data;
    end else if (state == io_pkg::uart_data && bit_end) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

endmodule

//--- logic/uart_rx.sv
/*
  8N1 receiver, LSB first, clocks_per_bit cycles per bit
  rx passes two flops, bits sampled at mid-bit
  a frame with a bad stop bit is dropped
  data_ready holds until go falls
*/
module uart_rx #(
  parameter int clocks_per_bit = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int cnt_w = clocks_per_bit > 1 ? $clog2(clocks_per_bit) : 1;

  io_pkg::uart_state_e state;
  logic [1:0]          sync;
  logic                rx_s;
  logic [cnt_w-1:0]    cnt;
  logic [2:0]          idx;
  logic [7:0]          shift;
  logic                bit_end;
  logic                half_bit;

  assign rx_s     = sync[1];
  assign bit_end  = cnt == cnt_w'(clocks_per_bit - 1);
  assign half_bit = cnt == cnt_w'((clocks_per_bit - 1) / 2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync       <= 2'b11;
      state      <= io_pkg::uart_idle;
      cnt        <= '0;
      idx        <= '0;
      data_ready <= 1'b0;
    end else begin
      sync <= {sync[0], rx};
      cnt  <= (state == io_pkg::uart_idle || bit_end) ? '0 : cnt + 1'b1;
      // acknowledge seen
      if (!go) begin
        data_ready <= 1'b0;
      end
      case (state)
        io_pkg::uart_idle: begin
          if (!rx_s) begin
            state <= io_pkg::uart_start;
          end
        end
        io_pkg::uart_start: begin
          // middle of start bit, realign so later samples hit mid-bit
          if (half_bit) begin
            cnt   <= '0;
            idx   <= '0;
            state <= rx_s ? io_pkg::uart_idle : io_pkg::uart_data;
          end
        end
        io_pkg::uart_data: begin
          if (bit_end) begin
            idx <= idx + 1'b1;
            if (idx == 3'd7) begin
              state <= io_pkg::uart_stop;
            end
          end
        end
        io_pkg::uart_stop: begin
          // rest of the stop bit is idle line anyway
          if (bit_end) begin
            state <= io_pkg::uart_idle;
            if (rx_s && go) begin
              data_ready <= 1'b1;
            end
          end
        end
        default: state <= io_pkg::uart_idle;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (state == io_pkg::uart_data && bit_end) begin
      shift <= {rx_s, shift[7:1]};
    end
    if (state == io_pkg::uart_stop && bit_end && rx_s) begin
      data <= shift;
    end
  end

endmodule

//--- logic/ramio.sv
/*
  bridge control: address decode, RAM read phase, LED and UART registers
  RAM reads take one extra cycle, I/O and RAM writes complete at once
  ram_address_bits + 2 must not exceed 32
  a new received byte overwrites an unread one
*/
module ramio #(
  parameter int ram_address_bits = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  mem_pkg::mem_req_t           req,
  output mem_pkg::mem_rsp_t           rsp,
  output mem_pkg::mem_req_t           lane_req,
  input  mem_pkg::ram_wr_t            ram_wr,
  output logic [3:0]                  ram_we,
  output logic [ram_address_bits-1:0] ram_addr,
  input  logic [31:0]                 ram_rd_ext,
  output logic [3:0]                  led,
  output logic [7:0]                  tx_data,
  output logic                        tx_go,
  input  logic                        tx_busy,
  output logic                        rx_go,
  input  logic [7:0]                  rx_data,
  input  logic                        rx_data_ready
);

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------
  logic        hit_led;
  logic        hit_out;
  logic        hit_in;
  logic        is_ram;
  logic        is_rd;
  logic        is_wr;
  logic        ram_rd;
  logic        rd_phase;
  logic [31:0] tx_reg;
  logic [31:0] rx_reg;

  assign hit_led = req.addr == io_pkg::addr_led;
  assign hit_out = req.addr == io_pkg::addr_uart_out;
  assign hit_in  = req.addr == io_pkg::addr_uart_in;

  // idle port counts as I/O so data_out_ready stays high
  assign is_ram = req.enable && !(hit_led || hit_out || hit_in);
  assign is_rd  = req.enable && req.read_kind != mem_pkg::rd_none;
  assign is_wr  = req.enable && req.write_kind != mem_pkg::wr_none;
  assign ram_rd = is_ram && is_rd;

  // ------------------------------------------------------------
  // RAM side
  // ------------------------------------------------------------
  // lane_align only steers lanes
  assign lane_req = req;

  assign ram_addr = req.addr[ram_address_bits+1:2];
  // writes to I/O addresses must never reach the RAM
  assign ram_we   = is_ram ? ram_wr.be : 4'b0000;

  // second cycle of a RAM read, registered word is valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_phase <= 1'b0;
    end else begin
      rd_phase <= ram_rd && !rd_phase;
    end
  end

  // ------------------------------------------------------------
  // response
  // ------------------------------------------------------------
  assign rsp.busy           = ram_rd && !rd_phase;
  assign rsp.data_out_ready = !ram_rd || rd_phase;

  always_comb begin
    rsp.rdata = 32'h0;
    if (is_rd) begin
      if (hit_out) begin
        rsp.rdata = tx_reg;
      end else if (hit_in) begin
        rsp.rdata = rx_reg;
      end else if (is_ram) begin
        rsp.rdata = ram_rd_ext;
      end
      // led register is write only, reads give zero
    end
  end

  // ------------------------------------------------------------
  // LED and UART registers
  // ------------------------------------------------------------
  assign tx_data = tx_reg[7:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led    <= 4'b1111;
      tx_reg <= io_pkg::io_idle;
      tx_go  <= 1'b0;
      rx_reg <= io_pkg::io_idle;
      rx_go  <= 1'b1;
    end else begin
      // a read empties the receive register
      if (hit_in && is_rd) begin
        rx_reg <= io_pkg::io_idle;
      end
      // take the byte and acknowledge, overrides the read clear
      if (rx_go && rx_data_ready) begin
        rx_reg <= {24'h0, rx_data};
        rx_go  <= 1'b0;
      end
      // ack lasts one cycle, then listen again
      if (!rx_go) begin
        rx_go <= 1'b1;
      end
      // frame done, close the handshake
      if (tx_go && !tx_busy) begin
        tx_go  <= 1'b0;
        tx_reg <= io_pkg::io_idle;
      end
      // new byte to send
      if (hit_out && is_wr) begin
        tx_reg <= {24'h0, req.wdata[7:0]};
        tx_go  <= 1'b1;
      end
      if (hit_led && is_wr) begin
        led <= req.wdata[3:0];
      end
    end
  end

endmodule

//--- logic/ramio_top.sv
/*
  bridge top: control, lane steering, word RAM and the UART pair
  RAM depth is 2**ram_address_bits words
*/
module ramio_top #(
  parameter int ram_address_bits = 8,
  parameter int clocks_per_bit   = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  mem_pkg::mem_req_t req,
  output mem_pkg::mem_rsp_t rsp,
  output logic [3:0]        led,
  output logic              uart_tx,
  input  logic              uart_rx
);

  mem_pkg::mem_req_t           lane_req;
  mem_pkg::ram_wr_t            ram_wr;
  logic [3:0]                  ram_we;
  logic [ram_address_bits-1:0] ram_addr;
  logic [31:0]                 ram_rdata;
  logic [31:0]                 ram_rd_ext;
  logic [7:0]                  tx_data;
  logic                        tx_go;
  logic                        tx_busy;
  logic                        rx_go;
  logic [7:0]                  rx_data;
  logic                        rx_data_ready;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------
  ramio #(
    .ram_address_bits(ram_address_bits)
  ) u_ramio (
    .clk,
    .rst_n,
    .req,
    .rsp,
    .lane_req,
    .ram_wr,
    .ram_we,
    .ram_addr,
    .ram_rd_ext,
    .led,
    .tx_data,
    .tx_go,
    .tx_busy,
    .rx_go,
    .rx_data,
    .rx_data_ready
  );

  // ------------------------------------------------------------
  // RAM datapath
  // ------------------------------------------------------------
  lane_align u_lane (
    .req   (lane_req),
    .ram_rd(ram_rdata),
    .wr    (ram_wr),
    .rd_ext(ram_rd_ext)
  );

  word_ram #(
    .ram_address_bits(ram_address_bits)
  ) u_ram (
    .clk,
    .addr (ram_addr),
    .we   (ram_we),
    .wdata(ram_wr.data),
    .rdata(ram_rdata)
  );

  // ------------------------------------------------------------
  // UART
  // ------------------------------------------------------------
  uart_tx #(
    .clocks_per_bit(clocks_per_bit)
  ) u_tx (
    .clk,
    .rst_n,
    .data(tx_data),
    .go  (tx_go),
    .busy(tx_busy),
    .tx  (uart_tx)
  );

  uart_rx #(
    .clocks_per_bit(clocks_per_bit)
  ) u_rx (
    .clk,
    .rst_n,
    .rx        (uart_rx),
    .go        (rx_go),
    .data      (rx_data),
    .data_ready(rx_data_ready)
  );

endmodule

//--- bench/ramio_assert.sv
/*
  concurrent checks on the bridge, bound into ramio
  covers the client handshake, the tx handshake and the LED reset value
*/
module ramio_assert (
  input logic              clk,
  input logic              rst_n,
  input mem_pkg::mem_rsp_t rsp,
  input logic              tx_go,
  input logic              tx_busy,
  input logic [3:0]        led
);

  // busy alone for one cycle, then ready with busy gone
  busy_excl: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.busy |-> !rsp.data_out_ready ##1 (rsp.data_out_ready && !rsp.busy))
    else $error("busy not followed by data_out_ready alone one cycle later");

  // go is only released after a frame, once busy has dropped
  go_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(tx_go) |-> $past(!tx_busy) && $past(tx_busy, 2))
    else $error("tx_go fell without a finished frame");

  leds_off: assert property (@(posedge clk) $rose(rst_n) |-> led == 4'b1111)
    else $error("LEDs not all off after reset");

endmodule

bind ramio ramio_assert u_assert (
  .clk,
  .rst_n,
  .rsp,
  .tx_go,
  .tx_busy,
  .led
);

//--- bench/ramio_tb.sv
/*
  directed testbench for the RAM and I/O bridge, UART tx looped back to rx
  RAM contents are only checked where the test has written them
  drives on the rising edge, samples on the falling edge
*/
module ramio_tb;

  localparam int period           = 40;
  localparam int clocks_per_bit   = 8;
  localparam int ram_address_bits = 8;
  localparam int word_tests       = 8;
  // loopback polls, each poll is two clocks
  localparam int poll_limit       = 15 * clocks_per_bit;
  // rough length of all tests in clocks, doubled for the watchdog
  localparam int test_cycles      = 600 + 40 * clocks_per_bit;
  localparam int timeout          = 2 * test_cycles * period;

  logic              clk;
  logic              rst_n;
  mem_pkg::mem_req_t req;
  mem_pkg::mem_rsp_t rsp;
  logic [3:0]        led;
  logic              uart_line;

  int          errors;
  int          checks;
  // byte model of the RAM, indexed by byte address
  logic [7:0]  ram_model [4 * 2**ram_address_bits];

  ramio_top #(
    .ram_address_bits(ram_address_bits),
    .clocks_per_bit  (clocks_per_bit)
  ) UUT (
    .clk,
    .rst_n,
    .req,
    .rsp,
    .led,
    .uart_tx(uart_line),
    .uart_rx(uart_line)
  );

  always #(period / 2) clk = ~clk;

  // ------------------------------------------------------------
  // check and reference model
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic void model_write(input logic [31:0] addr,
                                      input mem_pkg::write_kind_e wk,
                                      input logic [31:0] data);
    int base;
    base = int'(addr[ram_address_bits+1:0]);
    case (wk)
      mem_pkg::wr_byte: ram_model[base] = data[7:0];
      mem_pkg::wr_half: begin
        // odd address writes nothing
        if (!addr[0]) begin
          ram_model[base]     = data[7:0];
          ram_model[base + 1] = data[15:8];
        end
      end
      mem_pkg::wr_word: begin
        if (addr[1:0] == 2'b00) begin
          for (int i = 0; i < 4; i++) begin
            ram_model[base + i] = data[8*i +: 8];
          end
        end
      end
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr,
                                             input mem_pkg::read_kind_e rk,
                                             input logic sgn);
    int          base;
    logic [7:0]  b;
    logic [15:0] h;
    base = int'(addr[ram_address_bits+1:0]);
    case (rk)
      mem_pkg::rd_byte: begin
        b = ram_model[base];
        return sgn ? {{24{b[7]}}, b} : {24'h0, b};
      end
      mem_pkg::rd_half: begin
        if (addr[0]) begin
          return 32'h0;
        end
        h = {ram_model[base + 1], ram_model[base]};
        return sgn ? {{16{h[15]}}, h} : {16'h0, h};
      end
      mem_pkg::rd_word: begin
        if (addr[1:0] != 2'b00) begin
          return 32'h0;
        end
        return {ram_model[base + 3], ram_model[base + 2], ram_model[base + 1], ram_model[base]};
      end
      default: return 32'h0;
    endcase
  endfunction

  // ------------------------------------------------------------
  // bus access helpers
  // ------------------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one client access, held until data_out_ready, then the port goes idle
  task automatic access(input mem_pkg::read_kind_e rk, input logic sgn,
                        input mem_pkg::write_kind_e wk, input logic [31:0] addr,
                        input logic [31:0] wdata, output logic [31:0] rdata,
                        output int busy_cycles);
    mem_pkg::mem_req_t r;
    int                waited;
    r             = '0;
    r.enable      = 1'b1;
    r.read_kind   = rk;
    r.read_signed = sgn;
    r.write_kind  = wk;
    r.addr        = addr;
    r.wdata       = wdata;
    busy_cycles   = 0;
    waited        = 0;
    @(posedge clk);
    req <= r;
    @(negedge clk);
    while (!rsp.data_out_ready && waited < 8) begin
      if (rsp.busy) begin
        busy_cycles++;
      end
      waited++;
      @(negedge clk);
    end
    if (!rsp.data_out_ready) begin
      errors++;
      $display("access to address %h got no data_out_ready within 8 cycles", addr);
    end
    rdata = rsp.rdata;
    @(posedge clk);
    req <= '0;
  endtask

  task automatic ram_write(input logic [31:0] addr, input mem_pkg::write_kind_e wk,
                           input logic [31:0] data);
    logic [31:0] rd;
    int          bc;
    access(mem_pkg::rd_none, 1'b0, wk, addr, data, rd, bc);
    model_write(addr, wk, data);
    check_value("write busy cycles", 32'd0, bc);
  endtask

  // RAM read, expected value from the model, one busy cycle first
  task automatic ram_read_expect(input logic [31:0] addr, input mem_pkg::read_kind_e rk,
                                 input logic sgn, input string name);
    logic [31:0] rd;
    int          bc;
    access(rk, sgn, mem_pkg::wr_none, addr, 32'h0, rd, bc);
    check_value(name, model_read(addr, rk, sgn), rd);
    check_value("read busy cycles", 32'd1, bc);
  endtask

  task automatic io_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    int          bc;
    access(mem_pkg::rd_none, 1'b0, mem_pkg::wr_word, addr, data, rd, bc);
    check_value("io write busy cycles", 32'd0, bc);
  endtask

  task automatic io_read(input logic [31:0] addr, output logic [31:0] rdata);
    int bc;
    access(mem_pkg::rd_word, 1'b0, mem_pkg::wr_none, addr, 32'h0, rdata, bc);
    check_value("io read busy cycles", 32'd0, bc);
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic reset_state_check();
    logic [31:0] rd;
    @(negedge clk);
    check_value("led", 32'hf, {28'h0, led});
    check_value("uart_tx", 32'h1, {31'h0, uart_line});
    // idle port counts as I/O
    check_value("data_out_ready", 32'h1, {31'h0, rsp.data_out_ready});
    check_value("busy", 32'h0, {31'h0, rsp.busy});
    io_read(io_pkg::addr_uart_out, rd);
    check_value("uart_out", io_pkg::io_idle, rd);
    io_read(io_pkg::addr_uart_in, rd);
    check_value("uart_in", io_pkg::io_idle, rd);
  endtask

  task automatic ram_word_roundtrip();
    logic [31:0] addrs [$];
    logic [31:0] a;
    for (int i = 0; i < word_tests; i++) begin
      a = {22'h0, 8'($urandom % 256), 2'b00};
      addrs.push_back(a);
      ram_write(a, mem_pkg::wr_word, $urandom);
    end
    foreach (addrs[i]) begin
      ram_read_expect(addrs[i], mem_pkg::rd_word, 1'b0, "rdata word");
    end
  endtask

  task automatic sub_word_lanes();
    logic [31:0] base;
    base = {22'h0, 8'($urandom % 256), 2'b00};
    ram_write(base, mem_pkg::wr_word, $urandom);
    // one positive and one negative byte, one negative half
    ram_write(base, mem_pkg::wr_byte, $urandom & 32'h7f);
    ram_write(base + 1, mem_pkg::wr_byte, $urandom | 32'h80);
    ram_write(base + 2, mem_pkg::wr_half, $urandom | 32'h8000);
    ram_read_expect(base, mem_pkg::rd_word, 1'b0, "rdata word after lanes");
    for (int off = 0; off < 4; off++) begin
      ram_read_expect(base + off, mem_pkg::rd_byte, 1'b0, "rdata byte unsigned");
      ram_read_expect(base + off, mem_pkg::rd_byte, 1'b1, "rdata byte signed");
    end
    ram_read_expect(base, mem_pkg::rd_half, 1'b0, "rdata half unsigned");
    ram_read_expect(base, mem_pkg::rd_half, 1'b1, "rdata half signed");
    ram_read_expect(base + 2, mem_pkg::rd_half, 1'b0, "rdata half unsigned");
    ram_read_expect(base + 2, mem_pkg::rd_half, 1'b1, "rdata half signed");
    // misaligned reads give zero
    ram_read_expect(base + 1, mem_pkg::rd_half, 1'b1, "rdata misaligned half");
    ram_read_expect(base + 3, mem_pkg::rd_half, 1'b0, "rdata misaligned half");
    ram_read_expect(base + 2, mem_pkg::rd_word, 1'b0, "rdata misaligned word");
    // misaligned writes leave the word alone
    ram_write(base + 3, mem_pkg::wr_half, $urandom);
    ram_write(base + 1, mem_pkg::wr_word, $urandom);
    ram_read_expect(base, mem_pkg::rd_word, 1'b0, "rdata after misaligned writes");
  endtask

  task automatic led_register();
    logic [31:0] d;
    d    = $urandom;
    // at least one LED on so the write differs from the reset value
    d[3] = 1'b0;
    io_write(io_pkg::addr_led, d);
    @(negedge clk);
    check_value("led", {28'h0, d[3:0]}, {28'h0, led});
    // RAM traffic must not reach the LEDs
    ram_write({22'h0, 8'($urandom % 256), 2'b00}, mem_pkg::wr_word, ~d);
    @(negedge clk);
    check_value("led", {28'h0, d[3:0]}, {28'h0, led});
  endtask

  task automatic uart_loopback();
    logic [7:0]  b;
    logic [31:0] d;
    logic [31:0] rd;
    int          polls;
    for (int k = 0; k < 2; k++) begin
      b      = 8'($urandom);
      d      = $urandom;
      d[7:0] = b;
      io_write(io_pkg::addr_uart_out, d);
      // register shows the byte while the frame goes out
      io_read(io_pkg::addr_uart_out, rd);
      check_value("uart_out", {24'h0, b}, rd);
      polls = 0;
      rd    = io_pkg::io_idle;
      while (rd == io_pkg::io_idle && polls < poll_limit) begin
        io_read(io_pkg::addr_uart_in, rd);
        polls++;
      end
      if (rd == io_pkg::io_idle) begin
        errors++;
        $display("no byte came back on the UART loopback after %0d polls", polls);
      end else begin
        check_value("uart_in", {24'h0, b}, rd);
      end
      // the first read emptied the register
      io_read(io_pkg::addr_uart_in, rd);
      check_value("uart_in", io_pkg::io_idle, rd);
      // transmit register returns to idle once the tx handshake closes
      polls = 0;
      io_read(io_pkg::addr_uart_out, rd);
      while (rd != io_pkg::io_idle && polls < 2 * clocks_per_bit) begin
        io_read(io_pkg::addr_uart_out, rd);
        polls++;
      end
      check_value("uart_out", io_pkg::io_idle, rd);
      check_value("uart_tx", 32'h1, {31'h0, uart_line});
    end
  endtask

  // ------------------------------------------------------------
  // run
  // ------------------------------------------------------------
  initial begin
    void'($urandom(69638));
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    errors    = 0;
    checks    = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    reset_state_check();
    ram_word_roundtrip();
    sub_word_lanes();
    led_register();
    uart_loopback();
    wait_cycles(4);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeout);
    $display("timeout: tests did not complete within %0d time units", timeout);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- ramio_top.f
logic/mem_pkg.sv
logic/io_pkg.sv
logic/lane_align.sv
logic/word_ram.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/ramio.sv
logic/ramio_top.sv
bench/ramio_assert.sv
bench/ramio_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module ramio_tb \
  -f ramio_top.f \
  --Mdir obj_dir \
  -o ramio_sim

obj_dir/ramio_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run passed"
else
  echo "run failed"
  exit 1
fi
